// File: cr16_isa_pkg.sv
// instruction set encodings of the CR16 subset seen by the controller
// extension enums list only the codes that are decoded, any other code means no action
// shift extensions are matched on all four bits, the lsb is not treated as a don't care
package cr16_isa_pkg;

  // opcode and opcode extension share one field width
  localparam int OPCODE_W = 4;

  // ********************
  // major opcodes
  // ********************

  // 0110, 0111 and 1010 are immediate forms that the datapath lacks
  typedef enum logic [OPCODE_W-1:0] {
    OP_RS_RD   = 4'b0000,
    OP_ANDI    = 4'b0001,
    OP_ORI     = 4'b0010,
    OP_XORI    = 4'b0011,
    OP_LD_ST_J = 4'b0100,
    OP_ADDI    = 4'b0101,
    OP_SH      = 4'b1000,
    OP_SUBI    = 4'b1001,
    OP_CMPI    = 4'b1011,
    OP_BCOND   = 4'b1100,
    OP_MOVI    = 4'b1101,
    OP_MULI    = 4'b1110,
    OP_LUI     = 4'b1111
  } opcode_e;

  // ********************
  // opcode extensions
  // ********************

  // Rsrc/Rdest forms under OP_RS_RD
  typedef enum logic [OPCODE_W-1:0] {
    EXT_AND = 4'b0001,
    EXT_OR  = 4'b0010,
    EXT_XOR = 4'b0011,
    EXT_ADD = 4'b0101,
    EXT_SUB = 4'b1001,
    EXT_CMP = 4'b1011,
    EXT_MOV = 4'b1101,
    EXT_MUL = 4'b1110
  } rs_rd_ext_e;

  // shifts under OP_SH, the I forms take the amount from the immediate
  typedef enum logic [OPCODE_W-1:0] {
    EXT_LSHI  = 4'b0000,
    EXT_ASHUI = 4'b0010,
    EXT_LSH   = 4'b0100,
    EXT_ASHU  = 4'b0110
  } shift_ext_e;

  // memory and jump forms under OP_LD_ST_J
  typedef enum logic [OPCODE_W-1:0] {
    EXT_LOAD  = 4'b0000,
    EXT_STOR  = 4'b0100,
    EXT_JAL   = 4'b1000,
    EXT_JCOND = 4'b1100
  } ld_st_j_ext_e;

  // alu function select as seen by the datapath alu
  typedef enum logic [3:0] {
    ALU_ADD = 4'b0000,
    ALU_SUB = 4'b0001,
    ALU_AND = 4'b0010,
    ALU_OR  = 4'b0011,
    ALU_XOR = 4'b0100,
    ALU_NOT = 4'b0101,
    ALU_LSH = 4'b0110,
    ALU_ASH = 4'b0111,
    ALU_MUL = 4'b1000
  } alu_func_e;

endpackage

// File: cr16_ctrl_pkg.sv
// control side types of the CR16 controller
// exec_ctrl_t is 10 bits and alu_ctrl_t is 5 bits, the datapath depends on this layout
package cr16_ctrl_pkg;

  // ********************
  // phase and selects
  // ********************

  // IDLE is only seen during and right after reset
  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    FETCH   = 2'b01,
    EXECUTE = 2'b10
  } phase_e;

  // source of the register file write data
  typedef enum logic [2:0] {
    WB_ALU = 3'h0,
    WB_MEM = 3'h1,
    WB_REG = 3'h2,
    WB_IMM = 3'h3,
    WB_PC  = 3'h4
  } wb_sel_e;

  // next pc computation
  typedef enum logic [1:0] {
    PC_INCREMENT = 2'b00,
    PC_OFFSET    = 2'b01,
    PC_ABSOLUTE  = 2'b10
  } pc_mode_e;

  // alu second operand source
  localparam logic ALU_SRC_REG = 1'b0;
  localparam logic ALU_SRC_IMM = 1'b1;

  // ********************
  // control bundles
  // ********************

  // execute phase controls to the datapath and memory
  typedef struct packed {
    logic     reg_wr_en;
    logic     cmp_f_en;
    logic     of_f_en;
    logic     z_f_en;
    logic     mem_wr_en;
    pc_mode_e pc_addr_mode;
    wb_sel_e  write_back_sel;
  } exec_ctrl_t;

  // alu controls, valid in every phase
  typedef struct packed {
    logic                    alu_src;
    cr16_isa_pkg::alu_func_e alu_sel;
  } alu_ctrl_t;

  // no writes, no flags, pc increments, write back from alu
  localparam exec_ctrl_t EXEC_CTRL_DEFAULT = '{
    reg_wr_en:      1'b0,
    cmp_f_en:       1'b0,
    of_f_en:        1'b0,
    z_f_en:         1'b0,
    mem_wr_en:      1'b0,
    pc_addr_mode:   PC_INCREMENT,
    write_back_sel: WB_ALU
  };

  // register operand with add, used for anything that skips the alu
  localparam alu_ctrl_t ALU_CTRL_DEFAULT = '{
    alu_src: ALU_SRC_REG,
    alu_sel: cr16_isa_pkg::ALU_ADD
  };

endpackage

// File: cr16_phase_fsm.sv
// two phase sequencer, every instruction takes one fetch and one execute cycle
// decoded controls reach the outputs only in execute, other phases give the default
`timescale 1ns/1ns

module cr16_phase_fsm (
  input  logic                      clk,
  input  logic                      reset_n,
  input  cr16_ctrl_pkg::exec_ctrl_t decoded,
  output cr16_ctrl_pkg::exec_ctrl_t exec,
  output logic                      pc_en,
  output logic                      instr_en,
  output logic                      next_instr
);

  cr16_ctrl_pkg::phase_e phase;
  cr16_ctrl_pkg::phase_e phase_nxt;
  logic                  in_fetch;
  logic                  in_execute;

  // ********************
  // phase register
  // ********************

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      phase <= cr16_ctrl_pkg::IDLE;
    end else begin
      phase <= phase_nxt;
    end
  end

  // idle leaves to fetch, then fetch and execute alternate
  always_comb begin
    case (phase)
      cr16_ctrl_pkg::FETCH:   phase_nxt = cr16_ctrl_pkg::EXECUTE;
      cr16_ctrl_pkg::EXECUTE: phase_nxt = cr16_ctrl_pkg::FETCH;
      default:                phase_nxt = cr16_ctrl_pkg::FETCH;
    endcase
  end

  // ********************
  // strobes and gating
  // ********************

  assign in_fetch   = (phase == cr16_ctrl_pkg::FETCH);
  assign in_execute = (phase == cr16_ctrl_pkg::EXECUTE);

  // fetch loads the instruction register with pc as memory address
  assign instr_en   = in_fetch;
  assign next_instr = in_fetch;
  // pc advances at the end of execute
  assign pc_en      = in_execute;
  assign exec       = in_execute ? decoded : cr16_ctrl_pkg::EXEC_CTRL_DEFAULT;

endmodule

// File: cr16_exec_decode.sv
// combinational decode of the execute phase controls, no phase gating in here
// undecoded opcodes and extensions give the all inactive default
`timescale 1ns/1ns

module cr16_exec_decode (
  input  logic [cr16_isa_pkg::OPCODE_W-1:0] opcode,
  input  logic [cr16_isa_pkg::OPCODE_W-1:0] opcode_ext,
  input  logic                              cmp_result,
  output cr16_ctrl_pkg::exec_ctrl_t         decoded
);

  cr16_isa_pkg::opcode_e      op;
  cr16_isa_pkg::rs_rd_ext_e   rs_ext;
  cr16_isa_pkg::ld_st_j_ext_e mem_ext;

  // typed views of the instruction fields
  assign op      = cr16_isa_pkg::opcode_e'(opcode);
  assign rs_ext  = cr16_isa_pkg::rs_rd_ext_e'(opcode_ext);
  assign mem_ext = cr16_isa_pkg::ld_st_j_ext_e'(opcode_ext);

  always_comb begin
    decoded = cr16_ctrl_pkg::EXEC_CTRL_DEFAULT;
    case (op)
      // ********************
      // register forms
      // ********************
      cr16_isa_pkg::OP_RS_RD: begin
        case (rs_ext)
          // logic ops and multiply only report zero
          cr16_isa_pkg::EXT_AND,
          cr16_isa_pkg::EXT_OR,
          cr16_isa_pkg::EXT_MUL: begin
            decoded.reg_wr_en = 1'b1;
            decoded.z_f_en    = 1'b1;
          end
          cr16_isa_pkg::EXT_ADD: begin
            decoded.reg_wr_en = 1'b1;
            decoded.z_f_en    = 1'b1;
            decoded.of_f_en   = 1'b1;
          end
          // sub updates every flag
          cr16_isa_pkg::EXT_SUB: begin
            decoded.reg_wr_en = 1'b1;
            decoded.z_f_en    = 1'b1;
            decoded.of_f_en   = 1'b1;
            decoded.cmp_f_en  = 1'b1;
          end
          // compare only sets flags, Rdest is left alone
          cr16_isa_pkg::EXT_CMP: begin
            decoded.z_f_en   = 1'b1;
            decoded.cmp_f_en = 1'b1;
          end
          // copy Rsrc straight into Rdest
          cr16_isa_pkg::EXT_MOV: begin
            decoded.reg_wr_en      = 1'b1;
            decoded.write_back_sel = cr16_ctrl_pkg::WB_REG;
          end
          // xor selects the alu but writes nothing
          default: ;
        endcase
      end
      // ********************
      // memory and jumps
      // ********************
      cr16_isa_pkg::OP_LD_ST_J: begin
        case (mem_ext)
          cr16_isa_pkg::EXT_LOAD: begin
            decoded.reg_wr_en      = 1'b1;
            decoded.write_back_sel = cr16_ctrl_pkg::WB_MEM;
          end
          cr16_isa_pkg::EXT_STOR: decoded.mem_wr_en = 1'b1;
          // link register gets the pc, target comes from Rtarget
          cr16_isa_pkg::EXT_JAL: begin
            decoded.reg_wr_en      = 1'b1;
            decoded.write_back_sel = cr16_ctrl_pkg::WB_PC;
            decoded.pc_addr_mode   = cr16_ctrl_pkg::PC_ABSOLUTE;
          end
          // taken jump goes absolute, otherwise fall through
          cr16_isa_pkg::EXT_JCOND: begin
            decoded.pc_addr_mode = cmp_result ? cr16_ctrl_pkg::PC_ABSOLUTE
                                              : cr16_ctrl_pkg::PC_INCREMENT;
          end
          default: ;
        endcase
      end
      // every shift writes its result, whatever the extension
      cr16_isa_pkg::OP_SH: decoded.reg_wr_en = 1'b1;
      // ********************
      // immediate forms
      // ********************
      cr16_isa_pkg::OP_ANDI,
      cr16_isa_pkg::OP_ORI,
      cr16_isa_pkg::OP_XORI,
      cr16_isa_pkg::OP_MULI: begin
        decoded.reg_wr_en = 1'b1;
        decoded.z_f_en    = 1'b1;
      end
      // subi leaves the compare flag alone, unlike sub
      cr16_isa_pkg::OP_ADDI,
      cr16_isa_pkg::OP_SUBI: begin
        decoded.reg_wr_en = 1'b1;
        decoded.z_f_en    = 1'b1;
        decoded.of_f_en   = 1'b1;
      end
      cr16_isa_pkg::OP_CMPI: begin
        decoded.z_f_en   = 1'b1;
        decoded.cmp_f_en = 1'b1;
      end
      cr16_isa_pkg::OP_MOVI: begin
        decoded.reg_wr_en      = 1'b1;
        decoded.write_back_sel = cr16_ctrl_pkg::WB_IMM;
      end
      // taken branch adds the displacement to pc
      cr16_isa_pkg::OP_BCOND: begin
        decoded.pc_addr_mode = cmp_result ? cr16_ctrl_pkg::PC_OFFSET
                                          : cr16_ctrl_pkg::PC_INCREMENT;
      end
      // lui and the missing immediate opcodes do nothing
      default: ;
    endcase
  end

endmodule

// File: cr16_alu_decode.sv
// alu function and operand source decode, combinational and independent of phase
// opcodes that skip the alu get a register operand with add
`timescale 1ns/1ns

module cr16_alu_decode (
  input  logic [cr16_isa_pkg::OPCODE_W-1:0] opcode,
  input  logic [cr16_isa_pkg::OPCODE_W-1:0] opcode_ext,
  output cr16_ctrl_pkg::alu_ctrl_t          alu
);

  cr16_isa_pkg::opcode_e    op;
  cr16_isa_pkg::rs_rd_ext_e rs_ext;
  cr16_isa_pkg::shift_ext_e sh_ext;

  assign op     = cr16_isa_pkg::opcode_e'(opcode);
  assign rs_ext = cr16_isa_pkg::rs_rd_ext_e'(opcode_ext);
  assign sh_ext = cr16_isa_pkg::shift_ext_e'(opcode_ext);

  always_comb begin
    alu = cr16_ctrl_pkg::ALU_CTRL_DEFAULT;
    case (op)
      // ********************
      // register operand
      // ********************
      cr16_isa_pkg::OP_RS_RD: begin
        case (rs_ext)
          cr16_isa_pkg::EXT_AND: alu.alu_sel = cr16_isa_pkg::ALU_AND;
          cr16_isa_pkg::EXT_OR:  alu.alu_sel = cr16_isa_pkg::ALU_OR;
          cr16_isa_pkg::EXT_XOR: alu.alu_sel = cr16_isa_pkg::ALU_XOR;
          cr16_isa_pkg::EXT_ADD: alu.alu_sel = cr16_isa_pkg::ALU_ADD;
          // compare is a subtract whose result is dropped
          cr16_isa_pkg::EXT_SUB,
          cr16_isa_pkg::EXT_CMP: alu.alu_sel = cr16_isa_pkg::ALU_SUB;
          cr16_isa_pkg::EXT_MUL: alu.alu_sel = cr16_isa_pkg::ALU_MUL;
          // mov bypasses the alu
          default:               alu.alu_sel = cr16_isa_pkg::ALU_ADD;
        endcase
      end
      // shift amount from immediate or from Rsrc
      cr16_isa_pkg::OP_SH: begin
        case (sh_ext)
          cr16_isa_pkg::EXT_LSHI: begin
            alu.alu_src = cr16_ctrl_pkg::ALU_SRC_IMM;
            alu.alu_sel = cr16_isa_pkg::ALU_LSH;
          end
          cr16_isa_pkg::EXT_ASHUI: begin
            alu.alu_src = cr16_ctrl_pkg::ALU_SRC_IMM;
            alu.alu_sel = cr16_isa_pkg::ALU_ASH;
          end
          cr16_isa_pkg::EXT_LSH:  alu.alu_sel = cr16_isa_pkg::ALU_LSH;
          cr16_isa_pkg::EXT_ASHU: alu.alu_sel = cr16_isa_pkg::ALU_ASH;
          // unknown shift keeps register source with add
          default: ;
        endcase
      end
      // ********************
      // immediate operand
      // ********************
      cr16_isa_pkg::OP_ANDI,
      cr16_isa_pkg::OP_ORI,
      cr16_isa_pkg::OP_XORI,
      cr16_isa_pkg::OP_ADDI,
      cr16_isa_pkg::OP_SUBI,
      cr16_isa_pkg::OP_CMPI,
      cr16_isa_pkg::OP_MULI: begin
        alu.alu_src = cr16_ctrl_pkg::ALU_SRC_IMM;
        case (op)
          cr16_isa_pkg::OP_ANDI: alu.alu_sel = cr16_isa_pkg::ALU_AND;
          cr16_isa_pkg::OP_ORI:  alu.alu_sel = cr16_isa_pkg::ALU_OR;
          cr16_isa_pkg::OP_XORI: alu.alu_sel = cr16_isa_pkg::ALU_XOR;
          cr16_isa_pkg::OP_MULI: alu.alu_sel = cr16_isa_pkg::ALU_MUL;
          cr16_isa_pkg::OP_SUBI,
          cr16_isa_pkg::OP_CMPI: alu.alu_sel = cr16_isa_pkg::ALU_SUB;
          default:               alu.alu_sel = cr16_isa_pkg::ALU_ADD;
        endcase
      end
      // loads, stores, jumps, branches, movi and lui skip the alu
      default: ;
    endcase
  end

endmodule

// File: cr16_controller.sv
// CR16 control unit top, two cycles per instruction
// opcode, opcode_ext and cmp_result must hold steady over fetch and execute
`timescale 1ns/1ns

module cr16_controller (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic [cr16_isa_pkg::OPCODE_W-1:0] opcode,
  input  logic [cr16_isa_pkg::OPCODE_W-1:0] opcode_ext,
  input  logic                              cmp_result,
  output cr16_ctrl_pkg::exec_ctrl_t         exec,
  output cr16_ctrl_pkg::alu_ctrl_t          alu,
  output logic                              pc_en,
  output logic                              instr_en,
  output logic                              next_instr
);

  // ungated execute controls
  cr16_ctrl_pkg::exec_ctrl_t decoded;

  cr16_exec_decode i_exec_decode (
    .opcode     (opcode),
    .opcode_ext (opcode_ext),
    .cmp_result (cmp_result),
    .decoded    (decoded)
  );

  // sequencing and gating
  cr16_phase_fsm i_phase_fsm (
    .clk        (clk),
    .reset_n    (reset_n),
    .decoded    (decoded),
    .exec       (exec),
    .pc_en      (pc_en),
    .instr_en   (instr_en),
    .next_instr (next_instr)
  );

  // alu controls go straight out
  cr16_alu_decode i_alu_decode (
    .opcode     (opcode),
    .opcode_ext (opcode_ext),
    .alu        (alu)
  );

endmodule

// File: cr16_controller_sva.sv
// concurrent checks on the controller strobes and write enables
// all checks are off while reset_n is low
`timescale 1ns/1ns

module cr16_controller_sva (
  input logic                      clk,
  input logic                      reset_n,
  input logic                      pc_en,
  input logic                      instr_en,
  input cr16_ctrl_pkg::exec_ctrl_t exec
);

  // fetch and execute never overlap
  a_strobes_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(instr_en && pc_en))
    else $error("instr_en and pc_en are high in the same cycle");

  // every fetch is followed by its execute
  a_fetch_then_execute: assert property (@(posedge clk) disable iff (!reset_n)
    instr_en |=> pc_en)
    else $error("fetch cycle not followed by execute");

  // a store never writes the register file
  a_write_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(exec.mem_wr_en && exec.reg_wr_en))
    else $error("mem_wr_en and reg_wr_en are high together");

endmodule

bind cr16_controller cr16_controller_sva i_sva (
  .clk      (clk),
  .reset_n  (reset_n),
  .pc_en    (pc_en),
  .instr_en (instr_en),
  .exec     (exec)
);

// File: cr16_controller_tb.sv
// testbench for the CR16 controller, vectors and expected values come from the golden file
// each vector is held for one fetch and one execute cycle, outputs sampled on the falling edge
// golden file is read from the directory the simulator is started in
`timescale 1ns/1ns

module cr16_controller_tb;

  // one golden line, inputs first, then expected outputs
  typedef struct packed {
    logic [3:0]                opcode;
    logic [3:0]                opcode_ext;
    logic                      cmp_result;
    cr16_ctrl_pkg::exec_ctrl_t exec;
    cr16_ctrl_pkg::alu_ctrl_t  alu;
  } vector_t;

  localparam int RESET_CYCLES = 16;
  localparam int SLACK_CYCLES = 20;

  logic                      clk;
  logic                      reset_n;
  logic [3:0]                opcode;
  logic [3:0]                opcode_ext;
  logic                      cmp_result;
  cr16_ctrl_pkg::exec_ctrl_t exec;
  cr16_ctrl_pkg::alu_ctrl_t  alu;
  logic                      pc_en;
  logic                      instr_en;
  logic                      next_instr;

  vector_t vectors[$];
  int      errors = 0;
  int      cycles = 0;
  int      cycle_limit = 0;
  bit      loaded = 1'b0;

  cr16_controller i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .opcode     (opcode),
    .opcode_ext (opcode_ext),
    .cmp_result (cmp_result),
    .exec       (exec),
    .alu        (alu),
    .pc_en      (pc_en),
    .instr_en   (instr_en),
    .next_instr (next_instr)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ********************
  // expected values
  // ********************

  // outside execute: no writes, no flags, pc increments, write back from alu
  function automatic cr16_ctrl_pkg::exec_ctrl_t idle_exec();
    cr16_ctrl_pkg::exec_ctrl_t e;
    e.reg_wr_en      = 1'b0;
    e.cmp_f_en       = 1'b0;
    e.of_f_en        = 1'b0;
    e.z_f_en         = 1'b0;
    e.mem_wr_en      = 1'b0;
    e.pc_addr_mode   = cr16_ctrl_pkg::PC_INCREMENT;
    e.write_back_sel = cr16_ctrl_pkg::WB_ALU;
    return e;
  endfunction

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [3:0]  col [12];
    vector_t     v;
    fd = $fopen("cr16_controller_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open cr16_controller_golden.txt for reading");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // skip blank lines and # comments
      if (line.len() < 2 || line[0] == 8'h23) continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                  col[3], col[4], col[5], col[6], col[7], col[8], col[9], col[10], col[11]);
      if (n != 12) begin
        errors++;
        $display("golden line has %0d columns instead of 12: %s", n, line);
      end else begin
        v.opcode              = col[0];
        v.opcode_ext          = col[1];
        v.cmp_result          = col[2][0];
        v.exec.reg_wr_en      = col[3][0];
        v.exec.cmp_f_en       = col[4][0];
        v.exec.of_f_en        = col[5][0];
        v.exec.z_f_en         = col[6][0];
        v.exec.mem_wr_en      = col[7][0];
        v.exec.pc_addr_mode   = cr16_ctrl_pkg::pc_mode_e'(col[8][1:0]);
        v.exec.write_back_sel = cr16_ctrl_pkg::wb_sel_e'(col[9][2:0]);
        v.alu.alu_src         = col[10][0];
        v.alu.alu_sel         = cr16_isa_pkg::alu_func_e'(col[11]);
        vectors.push_back(v);
      end
    end
    $fclose(fd);
    loaded = (vectors.size() > 0);
  endtask

  // ********************
  // checks
  // ********************

  task automatic check_field(input string name, input logic [3:0] actual,
                             input logic [3:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic check_strobes(input string where, input logic pc_exp, input logic instr_exp,
                               input logic next_exp);
    check_field({where, " pc_en"}, 4'(pc_en), 4'(pc_exp));
    check_field({where, " instr_en"}, 4'(instr_en), 4'(instr_exp));
    check_field({where, " next_instr"}, 4'(next_instr), 4'(next_exp));
  endtask

  task automatic check_exec(input string where, input cr16_ctrl_pkg::exec_ctrl_t expected);
    check_field({where, " reg_wr_en"}, 4'(exec.reg_wr_en), 4'(expected.reg_wr_en));
    check_field({where, " cmp_f_en"}, 4'(exec.cmp_f_en), 4'(expected.cmp_f_en));
    check_field({where, " of_f_en"}, 4'(exec.of_f_en), 4'(expected.of_f_en));
    check_field({where, " z_f_en"}, 4'(exec.z_f_en), 4'(expected.z_f_en));
    check_field({where, " mem_wr_en"}, 4'(exec.mem_wr_en), 4'(expected.mem_wr_en));
    check_field({where, " pc_addr_mode"}, 4'(exec.pc_addr_mode), 4'(expected.pc_addr_mode));
    check_field({where, " write_back_sel"}, 4'(exec.write_back_sel),
                4'(expected.write_back_sel));
  endtask

  task automatic check_alu(input string where, input cr16_ctrl_pkg::alu_ctrl_t expected);
    check_field({where, " alu_src"}, 4'(alu.alu_src), 4'(expected.alu_src));
    check_field({where, " alu_sel"}, 4'(alu.alu_sel), 4'(expected.alu_sel));
  endtask

  // ********************
  // sequences
  // ********************

  // release on the last edge, so the last check sees the first cycle after reset
  task automatic run_reset();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      if (i == RESET_CYCLES - 1) reset_n <= 1'b1;
      @(negedge clk);
      check_strobes("reset", 1'b0, 1'b0, 1'b0);
      check_exec("reset", idle_exec());
      check_alu("reset", vectors[0].alu);
    end
  endtask

  // inputs change on the edge that starts fetch and hold through execute
  task automatic run_vector(input int idx, input vector_t v);
    @(posedge clk);
    opcode     <= v.opcode;
    opcode_ext <= v.opcode_ext;
    cmp_result <= v.cmp_result;
    @(negedge clk);
    check_strobes($sformatf("vector %0d fetch", idx), 1'b0, 1'b1, 1'b1);
    check_exec($sformatf("vector %0d fetch", idx), idle_exec());
    check_alu($sformatf("vector %0d fetch", idx), v.alu);
    @(posedge clk);
    @(negedge clk);
    check_strobes($sformatf("vector %0d execute", idx), 1'b1, 1'b0, 1'b0);
    check_exec($sformatf("vector %0d execute", idx), v.exec);
    check_alu($sformatf("vector %0d execute", idx), v.alu);
  endtask

  // watchdog, starts once the vector count is known
  initial begin
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("errors: %0d", errors);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    reset_n    = 1'b0;
    opcode     = 4'h0;
    opcode_ext = 4'h0;
    cmp_result = 1'b0;
    load_vectors();
    if (!loaded) begin
      errors++;
      $display("no usable vectors were read from the golden file");
      $display("errors: %0d", errors);
      $display("Simulation failed");
      $finish;
    end else begin
      cycle_limit = RESET_CYCLES + 2 + 2 * vectors.size() + SLACK_CYCLES;
      // alu decode is live during reset, so the first vector goes on at once
      opcode     = vectors[0].opcode;
      opcode_ext = vectors[0].opcode_ext;
      cmp_result = vectors[0].cmp_result;
      run_reset();
      for (int i = 0; i < vectors.size(); i++) begin
        run_vector(i, vectors[i]);
      end
      $display("errors: %0d in %0d vectors", errors, vectors.size());
      if (errors == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

// File: cr16_controller_golden.txt
# columns, all hex: opcode ext cmp_result | reg_wr cmp_f of_f z_f mem_wr pc_mode wb_sel | alu_src alu_sel
# pc_mode 0 inc 1 offset 2 absolute, wb_sel 0 alu 1 mem 2 reg 3 imm 4 pc, alu_src 1 = immediate
0 1 0  1 0 0 1 0 0 0  0 2
0 2 0  1 0 0 1 0 0 0  0 3
0 3 0  0 0 0 0 0 0 0  0 4
0 5 1  1 0 1 1 0 0 0  0 0
0 9 0  1 1 1 1 0 0 0  0 1
0 b 0  0 1 0 1 0 0 0  0 1
0 d 0  1 0 0 0 0 0 2  0 0
0 e 0  1 0 0 1 0 0 0  0 8
0 7 1  0 0 0 0 0 0 0  0 0
1 0 0  1 0 0 1 0 0 0  1 2
2 5 0  1 0 0 1 0 0 0  1 3
3 0 0  1 0 0 1 0 0 0  1 4
4 0 0  1 0 0 0 0 0 1  0 0
4 4 1  0 0 0 0 1 0 0  0 0
4 8 0  1 0 0 0 0 2 4  0 0
4 c 1  0 0 0 0 0 2 0  0 0
4 c 0  0 0 0 0 0 0 0  0 0
4 2 1  0 0 0 0 0 0 0  0 0
5 0 0  1 0 1 1 0 0 0  1 0
6 0 1  0 0 0 0 0 0 0  0 0
8 0 0  1 0 0 0 0 0 0  1 6
8 2 0  1 0 0 0 0 0 0  1 7
8 4 0  1 0 0 0 0 0 0  0 6
8 6 0  1 0 0 0 0 0 0  0 7
8 1 0  1 0 0 0 0 0 0  0 0
9 0 0  1 0 1 1 0 0 0  1 1
a 0 1  0 0 0 0 0 0 0  0 0
b 0 0  0 1 0 1 0 0 0  1 1
c 0 1  0 0 0 0 0 1 0  0 0
c 3 0  0 0 0 0 0 0 0  0 0
d 0 1  1 0 0 0 0 0 3  0 0
e 0 0  1 0 0 1 0 0 0  1 8
f 0 1  0 0 0 0 0 0 0  0 0

// File: cr16_controller.f
cr16_isa_pkg.sv
cr16_ctrl_pkg.sv
cr16_phase_fsm.sv
cr16_exec_decode.sv
cr16_alu_decode.sv
cr16_controller.sv
cr16_controller_sva.sv
cr16_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the controller testbench with Verilator and runs it
# exit status is non-zero on a build error, a run error or a failing test

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -f cr16_controller.f --top-module cr16_controller_tb -o cr16_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cr16_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
